// File: hw/dmmu_pkg.sv
// Shared definitions for the data-side MMU
// Page geometry, TLB size, TLB entry bit positions and the exception code.
// Every RTL file of the MMU imports this package.

package dmmu_pkg;

   // Address and data width
   localparam int addr_w = 32;

   // 8 KiB pages
   localparam int page_shift = 13;
   localparam int vpn_w      = addr_w - page_shift;
   localparam int ppn_w      = addr_w - page_shift;

   // Direct-mapped TLB with 128 sets
   localparam int tlb_sets_log2 = 7;
   localparam int tlb_sets      = 1 << tlb_sets_log2;

   // Byte write mask
   localparam int wmsk_w = addr_w / 8;

   // Low word of an entry
   localparam int lo_valid_bit = 0;
   // VPN tag occupies the upper bits of the low word
   localparam int lo_vpn_lsb   = page_shift;

   // High word of an entry
   // Bit 0 is the present flag, bit 7 non-cacheable and bit 8 shared.
   // Those three are kept in the memory and read back but not decoded here.
   localparam int hi_uw_bit  = 3;
   localparam int hi_ur_bit  = 4;
   localparam int hi_rw_bit  = 5;
   localparam int hi_rr_bit  = 6;
   // PPN occupies the upper bits of the high word
   localparam int hi_ppn_lsb = page_shift;

   // Exception code handed to the data cache with each access
   typedef enum logic [1:0] {
      exc_none       = 2'd0,
      exc_tlb_miss   = 2'd1,
      exc_page_fault = 2'd2
   } dmmu_exc_e;

endpackage

// File: hw/dmmu_stage_if.sv
// One memory access travelling from the lookup stage to the check stage
// The lookup stage drives the access as src, the check stage
// answers with ready as dst. Transfer happens when valid and ready are high.

interface dmmu_stage_if;
   import dmmu_pkg::*;

   logic                  valid;
   logic                  ready;
   logic [vpn_w-1:0]      vpn;
   logic [page_shift-1:0] offset;
   logic [wmsk_w-1:0]     wmsk;
   logic [addr_w-1:0]     wdata;
   // Mode bits sampled together with the access
   logic                  mmu_en;
   logic                  root_mode;

   modport src (
      output valid,
      output vpn,
      output offset,
      output wmsk,
      output wdata,
      output mmu_en,
      output root_mode,
      input  ready
   );

   modport dst (
      input  valid,
      input  vpn,
      input  offset,
      input  wmsk,
      input  wdata,
      input  mmu_en,
      input  root_mode,
      output ready
   );

endinterface

// File: hw/tlb_dpram.sv
// One word of every TLB set, held in a dual-port memory
// The lookup port reads under lk_en, the register port writes and reads back.
// A register write to the set being looked up is forwarded to the lookup read.
// Both reads are registered and show up one cycle after the index.

module tlb_dpram (
   input  logic                               clk,
   input  logic                               rst_n,
   // Lookup port
   input  logic                               lk_en,
   input  logic [dmmu_pkg::tlb_sets_log2-1:0] lk_idx,
   output logic [dmmu_pkg::addr_w-1:0]        lk_data,
   // Register port
   input  logic [dmmu_pkg::tlb_sets_log2-1:0] reg_idx,
   input  logic                               reg_we,
   input  logic [dmmu_pkg::addr_w-1:0]        reg_wdata,
   output logic [dmmu_pkg::addr_w-1:0]        reg_rdata
);
   import dmmu_pkg::*;

   logic [addr_w-1:0] mem [tlb_sets];
   logic              fwd_hit;

   assign fwd_hit = reg_we && (reg_idx == lk_idx);

   always_ff @(posedge clk) begin
      if (reg_we) begin
         mem[reg_idx] <= reg_wdata;
      end
   end

   // Lookup read, holds its word while lk_en is low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lk_data <= '0;
      end else if (lk_en) begin
         // Same-cycle write wins over the stored word
         lk_data <= fwd_hit ? reg_wdata : mem[lk_idx];
      end
   end

   // Register read back, write-first so new data shows the next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reg_rdata <= '0;
      end else if (reg_we) begin
         reg_rdata <= reg_wdata;
      end else begin
         reg_rdata <= mem[reg_idx];
      end
   end

endmodule

// File: hw/dmmu_lookup_stage.sv
// First MMU stage
// Accepts an access from the load/store unit, splits the address into VPN
// and page offset and launches the TLB read for the indexed set.
// Holds one access until the check stage takes it.

module dmmu_lookup_stage (
   input  logic                               clk,
   input  logic                               rst_n,
   // Load/store unit side
   input  logic                               req_valid,
   output logic                               req_ready,
   input  logic [dmmu_pkg::addr_w-1:0]        req_addr,
   input  logic [dmmu_pkg::wmsk_w-1:0]        req_wmsk,
   input  logic [dmmu_pkg::addr_w-1:0]        req_wdata,
   input  logic                               mmu_en,
   input  logic                               root_mode,
   // TLB lookup port
   output logic                               tlb_rd_en,
   output logic [dmmu_pkg::tlb_sets_log2-1:0] tlb_idx,
   // Toward the check stage
   dmmu_stage_if.src                          down
);
   import dmmu_pkg::*;

   logic                  valid_q;
   logic [vpn_w-1:0]      vpn_q;
   logic [page_shift-1:0] offset_q;
   logic [wmsk_w-1:0]     wmsk_q;
   logic [addr_w-1:0]     wdata_q;
   logic                  mmu_en_q;
   logic                  root_mode_q;
   logic                  adv;

   // Free slot, or the held access leaves on this edge
   assign req_ready = !valid_q || down.ready;
   assign adv       = req_valid && req_ready;

   // Set index comes straight from the incoming address
   assign tlb_idx   = req_addr[page_shift +: tlb_sets_log2];
   assign tlb_rd_en = adv;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (req_ready) begin
         valid_q <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (adv) begin
         vpn_q       <= req_addr[addr_w-1:page_shift];
         offset_q    <= req_addr[page_shift-1:0];
         wmsk_q      <= req_wmsk;
         wdata_q     <= req_wdata;
         mmu_en_q    <= mmu_en;
         root_mode_q <= root_mode;
      end
   end

   assign down.valid     = valid_q;
   assign down.vpn       = vpn_q;
   assign down.offset    = offset_q;
   assign down.wmsk      = wmsk_q;
   assign down.wdata     = wdata_q;
   assign down.mmu_en    = mmu_en_q;
   assign down.root_mode = root_mode_q;

endmodule

// File: hw/dmmu_check_stage.sv
// Second MMU stage
// Compares the TLB tag, checks the permission of the current mode and
// builds the physical address. The result is held on the dc_ outputs
// until the data cache takes it. Any exception clears the write mask.

module dmmu_check_stage (
   input  logic                        clk,
   input  logic                        rst_n,
   // From the lookup stage
   dmmu_stage_if.dst                   up,
   // Entry words of the set of the access in the lookup stage
   input  logic [dmmu_pkg::addr_w-1:0] tlb_lo,
   input  logic [dmmu_pkg::addr_w-1:0] tlb_hi,
   // Data cache side
   output logic                        dc_valid,
   input  logic                        dc_ready,
   output logic [dmmu_pkg::addr_w-1:0] dc_addr,
   output logic [dmmu_pkg::wmsk_w-1:0] dc_wmsk,
   output logic [dmmu_pkg::addr_w-1:0] dc_wdata,
   output dmmu_pkg::dmmu_exc_e         dc_exc
);
   import dmmu_pkg::*;

   logic              take;
   logic              tlb_v;
   logic [vpn_w-1:0]  tlb_vpn;
   logic [ppn_w-1:0]  tlb_ppn;
   logic              is_write;
   logic              perm_ok;
   logic              miss;
   logic              fault;
   dmmu_exc_e         exc_nxt;
   logic [addr_w-1:0] addr_nxt;
   logic [wmsk_w-1:0] wmsk_nxt;

   assign up.ready = !dc_valid || dc_ready;
   assign take     = up.valid && up.ready;

   // Entry fields
   assign tlb_v   = tlb_lo[lo_valid_bit];
   assign tlb_vpn = tlb_lo[addr_w-1:lo_vpn_lsb];
   assign tlb_ppn = tlb_hi[addr_w-1:hi_ppn_lsb];

   // Any enabled byte makes it a store
   assign is_write = |up.wmsk;

   always_comb begin
      if (up.root_mode) begin
         perm_ok = is_write ? tlb_hi[hi_rw_bit] : tlb_hi[hi_rr_bit];
      end else begin
         perm_ok = is_write ? tlb_hi[hi_uw_bit] : tlb_hi[hi_ur_bit];
      end
   end

   assign miss  = up.mmu_en && (!tlb_v || (tlb_vpn != up.vpn));
   assign fault = up.mmu_en && !miss && !perm_ok;

   always_comb begin
      if (miss) begin
         exc_nxt = exc_tlb_miss;
      end else if (fault) begin
         exc_nxt = exc_page_fault;
      end else begin
         exc_nxt = exc_none;
      end
   end

   // Translation bypassed when the MMU is off
   assign addr_nxt = up.mmu_en ? {tlb_ppn, up.offset} : {up.vpn, up.offset};
   assign wmsk_nxt = (exc_nxt == exc_none) ? up.wmsk : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dc_valid <= 1'b0;
         dc_exc   <= exc_none;
      end else begin
         if (up.ready) begin
            dc_valid <= up.valid;
         end
         if (take) begin
            dc_exc <= exc_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         dc_addr  <= addr_nxt;
         dc_wmsk  <= wmsk_nxt;
         dc_wdata <= up.wdata;
      end
   end

endmodule

// File: hw/dmmu_top.sv
// Data-side MMU of the 32-bit core
// Sits between the load/store unit and the data cache. Accesses go
// through a lookup stage and a check stage, both with valid/ready.
// TLB entries are written and read back through the tlbl_ and tlbh_ ports.

module dmmu_top (
   input  logic                               clk,
   input  logic                               rst_n,
   // Load/store unit
   input  logic                               req_valid,
   output logic                               req_ready,
   input  logic [dmmu_pkg::addr_w-1:0]        req_addr,
   input  logic [dmmu_pkg::wmsk_w-1:0]        req_wmsk,
   input  logic [dmmu_pkg::addr_w-1:0]        req_wdata,
   input  logic                               mmu_en,
   input  logic                               root_mode,
   // Data cache
   output logic                               dc_valid,
   input  logic                               dc_ready,
   output logic [dmmu_pkg::addr_w-1:0]        dc_addr,
   output logic [dmmu_pkg::wmsk_w-1:0]        dc_wmsk,
   output logic [dmmu_pkg::addr_w-1:0]        dc_wdata,
   output dmmu_pkg::dmmu_exc_e                dc_exc,
   // TLB low words
   input  logic [dmmu_pkg::tlb_sets_log2-1:0] tlbl_idx,
   input  logic [dmmu_pkg::addr_w-1:0]        tlbl_wdata,
   input  logic                               tlbl_we,
   output logic [dmmu_pkg::addr_w-1:0]        tlbl_rdata,
   // TLB high words
   input  logic [dmmu_pkg::tlb_sets_log2-1:0] tlbh_idx,
   input  logic [dmmu_pkg::addr_w-1:0]        tlbh_wdata,
   input  logic                               tlbh_we,
   output logic [dmmu_pkg::addr_w-1:0]        tlbh_rdata
);
   import dmmu_pkg::*;

   logic                     tlb_rd_en;
   logic [tlb_sets_log2-1:0] tlb_idx;
   logic [addr_w-1:0]        tlb_lo;
   logic [addr_w-1:0]        tlb_hi;

   dmmu_stage_if stage_if ();

   dmmu_lookup_stage lookup_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_wmsk  (req_wmsk),
      .req_wdata (req_wdata),
      .mmu_en    (mmu_en),
      .root_mode (root_mode),
      .tlb_rd_en (tlb_rd_en),
      .tlb_idx   (tlb_idx),
      .down      (stage_if.src)
   );

   // Valid bit and VPN tag
   tlb_dpram tlb_lo_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .lk_en     (tlb_rd_en),
      .lk_idx    (tlb_idx),
      .lk_data   (tlb_lo),
      .reg_idx   (tlbl_idx),
      .reg_we    (tlbl_we),
      .reg_wdata (tlbl_wdata),
      .reg_rdata (tlbl_rdata)
   );

   // Permission bits and PPN
   tlb_dpram tlb_hi_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .lk_en     (tlb_rd_en),
      .lk_idx    (tlb_idx),
      .lk_data   (tlb_hi),
      .reg_idx   (tlbh_idx),
      .reg_we    (tlbh_we),
      .reg_wdata (tlbh_wdata),
      .reg_rdata (tlbh_rdata)
   );

   dmmu_check_stage check_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .up       (stage_if.dst),
      .tlb_lo   (tlb_lo),
      .tlb_hi   (tlb_hi),
      .dc_valid (dc_valid),
      .dc_ready (dc_ready),
      .dc_addr  (dc_addr),
      .dc_wmsk  (dc_wmsk),
      .dc_wdata (dc_wdata),
      .dc_exc   (dc_exc)
   );

endmodule

// File: sim/dmmu_assertions.sv
// Concurrent checks on the data cache side of the MMU
// Bound into dmmu_top by the testbench. Each failed check raises $error
// and adds one to fail_count.

module dmmu_assertions (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        req_valid,
   input logic                        req_ready,
   input logic                        dc_valid,
   input logic                        dc_ready,
   input logic [dmmu_pkg::addr_w-1:0] dc_addr,
   input logic [dmmu_pkg::wmsk_w-1:0] dc_wmsk,
   input logic [dmmu_pkg::addr_w-1:0] dc_wdata,
   input dmmu_pkg::dmmu_exc_e         dc_exc
);
   timeunit 1ns;
   timeprecision 100ps;
   import dmmu_pkg::*;

   int   fail_count = 0;
   logic seen_req;

   // Set once the first access has been accepted
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         seen_req <= 1'b0;
      end else if (req_valid && req_ready) begin
         seen_req <= 1'b1;
      end
   end

   // Idle outputs until something goes in
   idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !seen_req |-> !dc_valid && dc_exc == exc_none && req_ready)
      else begin
         fail_count++;
         $error("dc side active before any access was accepted");
      end

   exc_clears_mask: assert property (@(posedge clk) disable iff (!rst_n)
      dc_valid && dc_exc != exc_none |-> dc_wmsk == '0)
      else begin
         fail_count++;
         $error("write mask not cleared on an exception");
      end

   // Result stays put while the cache stalls
   dc_hold: assert property (@(posedge clk) disable iff (!rst_n)
      dc_valid && !dc_ready |=> dc_valid && $stable(dc_addr) && $stable(dc_wmsk)
         && $stable(dc_wdata) && $stable(dc_exc))
      else begin
         fail_count++;
         $error("dc outputs changed while stalled");
      end

endmodule

// File: sim/dmmu_tb.sv
// Testbench for the data-side MMU
// Fills the TLB through the register ports and checks the words read back,
// then runs random accesses with the MMU off and on against a shadow TLB.
// Request gaps, dc_ready stalls and same-cycle TLB rewrites come from an LFSR.

module dmmu_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import dmmu_pkg::*;

   localparam int reset_cycles = 5;
   localparam int n_off        = 120;
   localparam int n_on         = 480;
   // Eight cycles for each TLB port operation and each access
   localparam int cycle_limit  = 8 * (2 * tlb_sets + n_off + n_on) + reset_cycles;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [wmsk_w-1:0] wmsk;
      logic [addr_w-1:0] wdata;
      dmmu_exc_e         exc;
   } result_t;

   logic                     clk;
   logic                     rst_n;
   logic                     req_valid;
   logic                     req_ready;
   logic [addr_w-1:0]        req_addr;
   logic [wmsk_w-1:0]        req_wmsk;
   logic [addr_w-1:0]        req_wdata;
   logic                     mmu_en;
   logic                     root_mode;
   logic                     dc_valid;
   logic                     dc_ready;
   logic [addr_w-1:0]        dc_addr;
   logic [wmsk_w-1:0]        dc_wmsk;
   logic [addr_w-1:0]        dc_wdata;
   dmmu_exc_e                dc_exc;
   logic [tlb_sets_log2-1:0] tlbl_idx;
   logic [addr_w-1:0]        tlbl_wdata;
   logic                     tlbl_we;
   logic [addr_w-1:0]        tlbl_rdata;
   logic [tlb_sets_log2-1:0] tlbh_idx;
   logic [addr_w-1:0]        tlbh_wdata;
   logic                     tlbh_we;
   logic [addr_w-1:0]        tlbh_rdata;

   logic [31:0]       lfsr_state = 32'h25c1;
   // Shadow TLB and what the register ports should show next
   logic [addr_w-1:0] sh_lo [tlb_sets];
   logic [addr_w-1:0] sh_hi [tlb_sets];
   bit                known_lo [tlb_sets];
   bit                known_hi [tlb_sets];
   logic [addr_w-1:0] exp_lo_rd;
   logic [addr_w-1:0] exp_hi_rd;
   bit                lo_rd_known;
   bit                hi_rd_known;
   result_t           exp_q [$];
   string             name_q [$];
   string             test_name;
   int                cycles = 0;
   logic              next_ready;

   dmmu_top dut_i (.*);

   bind dmmu_top dmmu_assertions assert_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .dc_valid  (dc_valid),
      .dc_ready  (dc_ready),
      .dc_addr   (dc_addr),
      .dc_wmsk   (dc_wmsk),
      .dc_wdata  (dc_wdata),
      .dc_exc    (dc_exc)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Fibonacci LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // Low word whose tag lands in its own set, valid most of the time
   function automatic logic [addr_w-1:0] rand_lo(logic [tlb_sets_log2-1:0] set);
      logic [addr_w-1:0] w;
      w = rand_bits(32);
      w[page_shift +: tlb_sets_log2] = set;
      w[lo_valid_bit] = rand_bits(3) != 0;
      return w;
   endfunction

   // Expected result of one access from the translation rules
   function automatic result_t predict(logic [addr_w-1:0] addr, logic [wmsk_w-1:0] wmsk,
                                      logic [addr_w-1:0] wdata, logic en, logic root,
                                      logic [addr_w-1:0] lo, logic [addr_w-1:0] hi);
      result_t r;
      logic    perm;
      r.addr  = addr;
      r.wmsk  = wmsk;
      r.wdata = wdata;
      r.exc   = exc_none;
      if (en) begin
         r.addr = {hi[addr_w-1:hi_ppn_lsb], addr[page_shift-1:0]};
         if (!lo[lo_valid_bit] || lo[addr_w-1:lo_vpn_lsb] != addr[addr_w-1:page_shift]) begin
            r.exc = exc_tlb_miss;
         end else begin
            if (root) begin
               perm = (|wmsk) ? hi[hi_rw_bit] : hi[hi_rr_bit];
            end else begin
               perm = (|wmsk) ? hi[hi_uw_bit] : hi[hi_ur_bit];
            end
            if (!perm) begin
               r.exc = exc_page_fault;
            end
         end
      end
      if (r.exc != exc_none) begin
         r.wmsk = '0;
      end
      return r;
   endfunction

   function automatic string show(result_t r);
      return $sformatf("addr=%h wmsk=%h wdata=%h exc=%s", r.addr, r.wmsk, r.wdata,
                       r.exc.name());
   endfunction

   task automatic abort_run(string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic tlb_write(logic [tlb_sets_log2-1:0] idx, logic [addr_w-1:0] lo,
                            logic [addr_w-1:0] hi);
      tlbl_idx   = idx;
      tlbh_idx   = idx;
      tlbl_wdata = lo;
      tlbh_wdata = hi;
      tlbl_we    = 1'b1;
      tlbh_we    = 1'b1;
      @(posedge clk);
      #1;
      tlbl_we = 1'b0;
      tlbh_we = 1'b0;
   endtask

   // One access, held until accepted
   task automatic send_access(logic en);
      logic [tlb_sets_log2-1:0] set;
      logic [addr_w-1:0]        addr;
      logic                     go;
      while (rand_bits(2) == 0) begin
         @(posedge clk);
         #1;
      end
      set  = 7'(rand_bits(tlb_sets_log2));
      addr = rand_bits(32);
      if (en) begin
         addr[page_shift +: tlb_sets_log2] = set;
         // Reuse the stored tag most of the time so that hits dominate
         if (rand_bits(2) != 0) begin
            addr[addr_w-1:page_shift] = sh_lo[set][addr_w-1:lo_vpn_lsb];
         end
         // Rewrite the set in the cycle the request is offered
         if (rand_bits(2) == 0) begin
            tlbl_idx   = set;
            tlbh_idx   = set;
            tlbl_wdata = rand_lo(set);
            tlbh_wdata = rand_bits(32);
            tlbl_we    = 1'b1;
            tlbh_we    = 1'b1;
         end
      end
      req_valid = 1'b1;
      req_addr  = addr;
      req_wmsk  = (rand_bits(1) != 0) ? 4'(rand_bits(4)) : '0;
      req_wdata = rand_bits(32);
      mmu_en    = en;
      root_mode = rand_bits(1) != 0;
      do begin
         @(negedge clk);
         go = req_ready;
         @(posedge clk);
         #1;
         tlbl_we = 1'b0;
         tlbh_we = 1'b0;
      end while (!go);
      req_valid = 1'b0;
   endtask

   // Cache back-pressure, drawn at the falling edge
   initial begin
      forever begin
         @(negedge clk);
         next_ready = rand_bits(2) != 0;
         @(posedge clk);
         #1;
         dc_ready = next_ready;
      end
   end

   // Everything is stable at the falling edge and describes the coming rising edge
   always @(negedge clk) begin
      result_t got;
      result_t exp;
      string   name;
      cycles++;
      if (cycles > cycle_limit) begin
         abort_run("timeout: the run did not finish within the cycle limit");
      end
      if (dut_i.assert_i.fail_count != 0) begin
         abort_run("an assertion on the DUT outputs failed");
      end
      if (rst_n) begin
         if (lo_rd_known && tlbl_rdata !== exp_lo_rd) begin
            abort_run($sformatf("error tlb_readback expected tlbl_rdata=%h actual %h",
                                exp_lo_rd, tlbl_rdata));
         end
         if (hi_rd_known && tlbh_rdata !== exp_hi_rd) begin
            abort_run($sformatf("error tlb_readback expected tlbh_rdata=%h actual %h",
                                exp_hi_rd, tlbh_rdata));
         end
         if (dc_valid && dc_ready) begin
            if (exp_q.size() == 0) begin
               abort_run("a result left the MMU with no access outstanding");
            end else begin
               exp  = exp_q.pop_front();
               name = name_q.pop_front();
               got  = {dc_addr, dc_wmsk, dc_wdata, dc_exc};
               if (got !== exp) begin
                  abort_run($sformatf("error %s expected %s actual %s", name, show(exp),
                                      show(got)));
               end
            end
         end
         lo_rd_known = tlbl_we || known_lo[tlbl_idx];
         hi_rd_known = tlbh_we || known_hi[tlbh_idx];
         exp_lo_rd   = tlbl_we ? tlbl_wdata : sh_lo[tlbl_idx];
         exp_hi_rd   = tlbh_we ? tlbh_wdata : sh_hi[tlbh_idx];
         if (tlbl_we) begin
            sh_lo[tlbl_idx]    = tlbl_wdata;
            known_lo[tlbl_idx] = 1'b1;
         end
         if (tlbh_we) begin
            sh_hi[tlbh_idx]    = tlbh_wdata;
            known_hi[tlbh_idx] = 1'b1;
         end
         // A lookup sees a write to its set on the same edge
         if (req_valid && req_ready) begin
            exp_q.push_back(predict(req_addr, req_wmsk, req_wdata, mmu_en, root_mode,
                                    sh_lo[req_addr[page_shift +: tlb_sets_log2]],
                                    sh_hi[req_addr[page_shift +: tlb_sets_log2]]));
            name_q.push_back(test_name);
         end
      end
   end

   initial begin
      rst_n      = 1'b0;
      req_valid  = 1'b0;
      req_addr   = '0;
      req_wmsk   = '0;
      req_wdata  = '0;
      mmu_en     = 1'b0;
      root_mode  = 1'b0;
      dc_ready   = 1'b0;
      tlbl_idx   = '0;
      tlbl_wdata = '0;
      tlbl_we    = 1'b0;
      tlbh_idx   = '0;
      tlbh_wdata = '0;
      tlbh_we    = 1'b0;
      test_name  = "reset";
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // Fill every set, then walk the read index over all of them
      test_name = "tlb_fill";
      for (int i = 0; i < tlb_sets; i++) begin
         tlb_write(7'(i), rand_lo(7'(i)), rand_bits(32));
      end
      for (int i = 0; i < tlb_sets; i++) begin
         tlbl_idx = 7'(i);
         tlbh_idx = 7'(i);
         @(posedge clk);
         #1;
      end
      test_name = "mmu_off";
      repeat (n_off) send_access(1'b0);
      test_name = "translate";
      repeat (n_on) send_access(1'b1);
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      if (dut_i.assert_i.fail_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         abort_run("an assertion on the DUT outputs failed at the end of the run");
      end
   end

endmodule

// File: build.f
hw/dmmu_pkg.sv
hw/dmmu_stage_if.sv
hw/tlb_dpram.sv
hw/dmmu_lookup_stage.sv
hw/dmmu_check_stage.sv
hw/dmmu_top.sv
sim/dmmu_assertions.sv
sim/dmmu_tb.sv

// File: Makefile
# Verilator build and run of the data-side MMU testbench
# The simulator's exit status is the test verdict.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module dmmu_tb -Mdir obj_dir -o dmmu_sim -f build.f
	./obj_dir/dmmu_sim +verilator+error+limit+1000

clean:
	rm -rf obj_dir
